// ==== common/riscv_core_pkg.sv ====
package riscv_core_pkg;

   localparam int IMM_W = 64; // Widest supported XLEN

   //////////////////////////////////////////////////
   // Major opcodes
   //////////////////////////////////////////////////
   localparam logic [6:0] OPC_OP        = 7'b0110011;
   localparam logic [6:0] OPC_OP_32     = 7'b0111011;
   localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
   localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
   localparam logic [6:0] OPC_LOAD      = 7'b0000011;
   localparam logic [6:0] OPC_STORE     = 7'b0100011;
   localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
   localparam logic [6:0] OPC_JAL       = 7'b1101111;
   localparam logic [6:0] OPC_JALR      = 7'b1100111;
   localparam logic [6:0] OPC_LUI       = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
   localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;
   localparam logic [6:0] OPC_AMO       = 7'b0101111;

   typedef enum logic [2:0] {
      IMM_I    = 3'd0,
      IMM_S    = 3'd1,
      IMM_B    = 3'd2,
      IMM_J    = 3'd3,
      IMM_U    = 3'd4,
      IMM_ZERO = 3'd5, // Atomics address rs1 directly
      IMM_CSR  = 3'd6  // zimm from rs1 field
   } imm_src_e;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL,
      ALU_SRA, ALU_OR, ALU_AND, ALU_MUL, ALU_DIV, ALU_REM
   } alu_op_e;

   //////////////////////////////////////////////////
   // Decode structures
   //////////////////////////////////////////////////
   typedef struct packed {
      logic [6:0] funct7; // [31:25]
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode; // [6:0]
   } instr_fields_t;

   typedef struct packed {
      logic       regwrite;
      imm_src_e   imm_src;
      logic       u_ctrl;     // LUI passes immediate straight through
      logic       alu_src_b;
      logic       mem_write;
      logic [1:0] result_src; // 0 ALU, 1 memory, 2 PC+4, 3 CSR
      logic       branch;
      logic       alu_op;
      logic [1:0] size;       // Byte, half, word, double
      logic       load_ext;   // Zero-extend load data
      logic       is_word;
      logic       jump;
      logic       bj_reg;     // Target base is rs1
      logic       imm_sel;    // M extension select
   } ctrl_t;

   typedef struct packed {
      logic       amo;
      logic [3:0] amo_op;
      logic       lr;
      logic       sc;
   } amo_t;

   typedef struct packed {
      logic       src_sel; // Immediate source when set
      logic [1:0] op;      // 1 write, 2 set, 3 clear
   } csr_t;

   typedef struct packed {
      ctrl_t              ctrl;
      amo_t               amo;
      csr_t               csr;
      logic               new_mux_sel;
      logic               read;
      logic               illegal;
      alu_op_e            alu_ctrl;
      logic [4:0]         rd;
      logic [4:0]         rs1;
      logic [4:0]         rs2;
      logic [IMM_W-1:0]   imm;
   } decode_t;

endpackage

// ==== source/riscv_core_main_decoder.sv ====
`timescale 1ns/1ps

module riscv_core_main_decoder
   import riscv_core_pkg::*;
(
   input  logic [6:0] i_opcode,
   input  logic [2:0] i_funct3,
   input  logic [6:0] i_funct7,
   output ctrl_t      o_ctrl,
   output amo_t       o_amo,
   output csr_t       o_csr,
   output logic       o_new_mux_sel,
   output logic       o_read,
   output logic       o_illegal
);

   logic [4:0] funct5;

   assign funct5 = i_funct7[6:2]; // AMO operation field

   always_comb begin : ctrl_proc
      o_ctrl    = '0;
      o_illegal = 1'b0;
      case (i_opcode)
         OPC_OP: begin
            o_ctrl.regwrite = 1'b1;
            o_ctrl.alu_op   = 1'b1;
            o_ctrl.imm_sel  = i_funct7[0]; // MUL/DIV/REM group
         end
         OPC_OP_32: begin
            o_ctrl.regwrite = 1'b1;
            o_ctrl.alu_op   = 1'b1;
            o_ctrl.is_word  = 1'b1;
            o_ctrl.imm_sel  = i_funct7[0];
         end
         OPC_OP_IMM: begin
            o_ctrl.regwrite  = 1'b1;
            o_ctrl.alu_src_b = 1'b1;
            o_ctrl.alu_op    = 1'b1;
         end
         OPC_OP_IMM_32: begin
            o_ctrl.regwrite  = 1'b1;
            o_ctrl.alu_src_b = 1'b1;
            o_ctrl.alu_op    = 1'b1;
            o_ctrl.is_word   = 1'b1;
         end
         OPC_LOAD: begin
            o_ctrl.regwrite   = 1'b1;
            o_ctrl.alu_src_b  = 1'b1;
            o_ctrl.result_src = 2'b01;
            o_ctrl.size       = i_funct3[1:0];
            o_ctrl.load_ext   = i_funct3[2]; // LBU, LHU, LWU
         end
         OPC_STORE: begin
            o_ctrl.imm_src   = IMM_S;
            o_ctrl.alu_src_b = 1'b1;
            o_ctrl.mem_write = 1'b1;
            o_ctrl.size      = i_funct3[1:0];
         end
         OPC_BRANCH: begin
            o_ctrl.imm_src   = IMM_B;
            o_ctrl.alu_src_b = 1'b1;
            o_ctrl.branch    = 1'b1; // Compare done in execute
         end
         OPC_JAL: begin
            o_ctrl.regwrite   = 1'b1;
            o_ctrl.imm_src    = IMM_J;
            o_ctrl.alu_src_b  = 1'b1;
            o_ctrl.result_src = 2'b10;
            o_ctrl.jump       = 1'b1;
         end
         OPC_JALR: begin
            o_ctrl.regwrite   = 1'b1;
            o_ctrl.alu_src_b  = 1'b1;
            o_ctrl.result_src = 2'b10;
            o_ctrl.jump       = 1'b1;
            o_ctrl.bj_reg     = 1'b1;
         end
         OPC_LUI: begin
            o_ctrl.regwrite  = 1'b1;
            o_ctrl.imm_src   = IMM_U;
            o_ctrl.u_ctrl    = 1'b1;
            o_ctrl.alu_src_b = 1'b1;
         end
         OPC_AUIPC: begin
            o_ctrl.regwrite  = 1'b1;
            o_ctrl.imm_src   = IMM_U;
            o_ctrl.alu_src_b = 1'b1;
         end
         OPC_SYSTEM: begin
            o_ctrl.regwrite   = 1'b1;
            o_ctrl.imm_src    = IMM_CSR;
            o_ctrl.result_src = 2'b11; // Old CSR value to rd
         end
         OPC_AMO: begin
            o_ctrl.regwrite   = 1'b1;
            o_ctrl.imm_src    = IMM_ZERO;
            o_ctrl.alu_src_b  = 1'b1;
            o_ctrl.mem_write  = 1'b1;
            o_ctrl.result_src = 2'b01;
            o_ctrl.size       = i_funct3[0] ? 2'b11 : 2'b10; // .D or .W
            o_ctrl.load_ext   = (funct5[4:3] == 2'b11); // Unsigned min/max compare
         end
         default: o_illegal = 1'b1;
      endcase
   end

   //////////////////////////////////////////////////
   // Atomic operation
   //////////////////////////////////////////////////
   always_comb begin : amo_proc
      o_amo = '0;
      if (i_opcode == OPC_AMO) begin
         case (funct5)
            5'b00010: o_amo.lr = 1'b1;
            5'b00011: o_amo.sc = 1'b1;
            5'b00001: o_amo    = '{amo: 1'b1, amo_op: 4'd0, lr: 1'b0, sc: 1'b0}; // SWAP
            5'b00000: o_amo    = '{amo: 1'b1, amo_op: 4'd1, lr: 1'b0, sc: 1'b0}; // ADD
            5'b01100: o_amo    = '{amo: 1'b1, amo_op: 4'd2, lr: 1'b0, sc: 1'b0}; // AND
            5'b01000: o_amo    = '{amo: 1'b1, amo_op: 4'd3, lr: 1'b0, sc: 1'b0}; // OR
            5'b00100: o_amo    = '{amo: 1'b1, amo_op: 4'd4, lr: 1'b0, sc: 1'b0}; // XOR
            5'b10100: o_amo    = '{amo: 1'b1, amo_op: 4'd5, lr: 1'b0, sc: 1'b0}; // MAX
            5'b10000: o_amo    = '{amo: 1'b1, amo_op: 4'd6, lr: 1'b0, sc: 1'b0}; // MIN
            5'b11100: o_amo    = '{amo: 1'b1, amo_op: 4'd7, lr: 1'b0, sc: 1'b0}; // MAXU
            5'b11000: o_amo    = '{amo: 1'b1, amo_op: 4'd8, lr: 1'b0, sc: 1'b0}; // MINU
            default:  o_amo    = '0;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // CSR source and operation
   //////////////////////////////////////////////////
   always_comb begin : csr_proc
      o_csr = '0;
      if (i_opcode == OPC_SYSTEM) begin
         o_csr.src_sel = i_funct3[2];   // CSRR*I forms
         o_csr.op      = i_funct3[1:0]; // 0 leaves ECALL/EBREAK inert
      end
   end

   //////////////////////////////////////////////////
   // Read and new mux select
   //////////////////////////////////////////////////
   always_comb begin : read_proc
      case (i_opcode)
         OPC_LOAD: o_read = 1'b1;
         OPC_LUI:  o_read = 1'b1;
         OPC_AMO:  o_read = (funct5 != 5'b00011); // SC only writes
         default:  o_read = 1'b0;
      endcase
   end

   always_comb begin : new_mux_sel_proc
      case (i_opcode)
         OPC_BRANCH, OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC: o_new_mux_sel = 1'b1;
         default: o_new_mux_sel = 1'b0;
      endcase
   end

endmodule

// ==== source/riscv_core_alu_decoder.sv ====
`timescale 1ns/1ps

module riscv_core_alu_decoder
   import riscv_core_pkg::*;
(
   input  logic [6:0] i_opcode,
   input  logic [2:0] i_funct3,
   input  logic [6:0] i_funct7,
   input  logic       i_alu_op,
   input  logic       i_imm_sel,
   output alu_op_e    o_alu_ctrl
);

   logic reg_form;
   logic alt_form;

   // OP and OP-32 have bit 5 set, the immediate forms do not
   assign reg_form = i_opcode[5];
   assign alt_form = i_funct7[5]; // SUB and SRA marker

   //////////////////////////////////////////////////
   // Operation select
   //////////////////////////////////////////////////
   always_comb begin : alu_ctrl_proc
      o_alu_ctrl = ALU_ADD; // Loads, stores, jumps, atomics
      if (i_alu_op) begin
         if (i_imm_sel) begin
            if (!i_funct3[2]) begin
               o_alu_ctrl = ALU_MUL; // MUL, MULH, MULHSU, MULHU
            end
            else if (!i_funct3[1]) begin
               o_alu_ctrl = ALU_DIV; // DIV, DIVU
            end
            else begin
               o_alu_ctrl = ALU_REM; // REM, REMU
            end
         end
         else begin
            case (i_funct3)
               3'd0: begin
                  if (reg_form && alt_form) begin
                     o_alu_ctrl = ALU_SUB;
                  end
                  else begin
                     o_alu_ctrl = ALU_ADD; // ADDI has no SUB twin
                  end
               end
               3'd1: o_alu_ctrl = ALU_SLL;
               3'd2: o_alu_ctrl = ALU_SLT;
               3'd3: o_alu_ctrl = ALU_SLTU;
               3'd4: o_alu_ctrl = ALU_XOR;
               3'd5: begin
                  if (alt_form) begin
                     o_alu_ctrl = ALU_SRA;
                  end
                  else begin
                     o_alu_ctrl = ALU_SRL;
                  end
               end
               3'd6: o_alu_ctrl = ALU_OR;
               default: o_alu_ctrl = ALU_AND;
            endcase
         end
      end
   end

endmodule

// ==== source/riscv_core_imm_extend.sv ====
`timescale 1ns/1ps

module riscv_core_imm_extend
   import riscv_core_pkg::*;
#(
   parameter int XLEN = 64
) (
   input  logic [31:0]     i_instr,
   input  imm_src_e        i_imm_src,
   output logic [XLEN-1:0] o_imm
);

   logic signed [31:0] imm32;

   always_comb begin : imm_proc
      case (i_imm_src)
         IMM_I: imm32 = {{20{i_instr[31]}}, i_instr[31:20]};
         IMM_S: imm32 = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
         IMM_B: begin
            imm32 = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                     i_instr[30:25], i_instr[11:8], 1'b0};
         end
         IMM_J: begin
            imm32 = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                     i_instr[20], i_instr[30:21], 1'b0};
         end
         IMM_U:    imm32 = {i_instr[31:12], 12'b0};
         IMM_CSR:  imm32 = {27'b0, i_instr[19:15]}; // zimm, never negative
         default:  imm32 = '0;                       // IMM_ZERO
      endcase
   end

   // Signed cast carries bit 31 up to XLEN
   assign o_imm = XLEN'(imm32);

endmodule

// ==== source/riscv_core_decode_stage.sv ====
`timescale 1ns/1ps

module riscv_core_decode_stage
   import riscv_core_pkg::*;
#(
   parameter int XLEN = 64
) (
   input  logic        i_clk,
   input  logic        i_rst_n,
   input  logic [31:0] i_instr,
   input  logic        i_instr_valid,
   output logic        o_instr_ready,
   output decode_t     o_dec,
   output logic        o_dec_valid,
   input  logic        i_dec_ready
);

   instr_fields_t           fields;
   ctrl_t                   ctrl;
   amo_t                    amo;
   csr_t                    csr;
   logic                    new_mux_sel;
   logic                    read;
   logic                    illegal;
   alu_op_e                 alu_ctrl;
   logic signed [XLEN-1:0]  imm_ext;
   decode_t                 dec_next;
   decode_t                 dec_q;
   logic                    valid_q;

   assign fields = instr_fields_t'(i_instr);

   //////////////////////////////////////////////////
   // Decoders
   //////////////////////////////////////////////////
   riscv_core_main_decoder u_main_decoder (
      .i_opcode      (fields.opcode),
      .i_funct3      (fields.funct3),
      .i_funct7      (fields.funct7),
      .o_ctrl        (ctrl),
      .o_amo         (amo),
      .o_csr         (csr),
      .o_new_mux_sel (new_mux_sel),
      .o_read        (read),
      .o_illegal     (illegal)
   );

   riscv_core_alu_decoder u_alu_decoder (
      .i_opcode   (fields.opcode),
      .i_funct3   (fields.funct3),
      .i_funct7   (fields.funct7),
      .i_alu_op   (ctrl.alu_op),
      .i_imm_sel  (ctrl.imm_sel),
      .o_alu_ctrl (alu_ctrl)
   );

   riscv_core_imm_extend #(
      .XLEN (XLEN)
   ) u_imm_extend (
      .i_instr   (i_instr),
      .i_imm_src (ctrl.imm_src),
      .o_imm     (imm_ext)
   );

   always_comb begin : assemble_proc
      dec_next.ctrl        = ctrl;
      dec_next.amo         = amo;
      dec_next.csr         = csr;
      dec_next.new_mux_sel = new_mux_sel;
      dec_next.read        = read;
      dec_next.illegal     = illegal;
      dec_next.alu_ctrl    = alu_ctrl;
      dec_next.rd          = fields.rd;
      dec_next.rs1         = fields.rs1;
      dec_next.rs2         = fields.rs2;
      dec_next.imm         = IMM_W'(imm_ext); // Sign-extend when XLEN is 32
   end

   //////////////////////////////////////////////////
   // Pipeline register
   //////////////////////////////////////////////////
   // Take a new item when empty or when the held one leaves this cycle
   assign o_instr_ready = !valid_q || i_dec_ready;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         valid_q <= 1'b0;
      end
      else if (o_instr_ready) begin
         valid_q <= i_instr_valid;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_instr_valid && o_instr_ready) begin
         dec_q <= dec_next; // Held stable under back-pressure
      end
   end

   assign o_dec       = dec_q;
   assign o_dec_valid = valid_q;

endmodule

// ==== tests/riscv_core_decode_checker.sv ====
`timescale 1ns/1ps

module riscv_core_decode_checker
   import riscv_core_pkg::*;
(
   input logic    i_clk,
   input logic    i_rst_n,
   input decode_t i_dec,
   input logic    i_dec_valid,
   input logic    i_dec_ready
);

   //////////////////////////////////////////////////
   // Output handshake
   //////////////////////////////////////////////////
   a_valid_low_after_reset : assert property (@(posedge i_clk)
      !i_rst_n |=> !i_dec_valid)
      else $error("o_dec_valid high right after reset");

   // Held item must not change or vanish under back-pressure
   a_hold_stable : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_dec_valid && !i_dec_ready |=> i_dec_valid && $stable(i_dec))
      else $error("o_dec changed while stalled");

   //////////////////////////////////////////////////
   // Decode consistency
   //////////////////////////////////////////////////
   a_illegal_inert : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_dec_valid && i_dec.illegal |->
         !i_dec.ctrl.regwrite && !i_dec.ctrl.mem_write && !i_dec.amo.amo)
      else $error("Illegal instruction carries live controls");

endmodule

bind riscv_core_decode_stage riscv_core_decode_checker u_checker (
   .i_clk       (i_clk),
   .i_rst_n     (i_rst_n),
   .i_dec       (o_dec),
   .i_dec_valid (o_dec_valid),
   .i_dec_ready (i_dec_ready)
);

// ==== tests/riscv_core_decode_tb.sv ====
`timescale 1ns/1ps

module riscv_core_decode_tb
   import riscv_core_pkg::*;
;

   localparam int K_OP     = 0;
   localparam int K_OP32   = 1;
   localparam int K_OPIMM  = 2;
   localparam int K_LOAD   = 3;
   localparam int K_STORE  = 4;
   localparam int K_BRANCH = 5;
   localparam int K_JAL    = 6;
   localparam int K_JALR   = 7;
   localparam int K_LUI    = 8;
   localparam int K_AUIPC  = 9;
   localparam int K_CSR    = 10;
   localparam int K_AMO    = 11;
   localparam int K_BAD    = 12;

   typedef struct {
      string       name;
      logic [31:0] instr;
      ctrl_t       ctrl;
      amo_t        amo;
      csr_t        csr;
      alu_op_e     alu;
      logic        ill;
      logic        rd_flag;
      logic        new_mux;
      logic [63:0] imm;
   } entry_t;

   logic        i_clk;
   logic        i_rst_n;
   logic [31:0] i_instr;
   logic        i_instr_valid;
   logic        o_instr_ready;
   decode_t     o_dec;
   logic        o_dec_valid;
   logic        i_dec_ready;

   entry_t      tbl[$];
   logic [31:0] rng;
   int          sent;
   int          recv;
   int          pass_cnt;
   int          fail_cnt;
   int          proto_errs;
   int          idle;
   int          errs;
   logic        in_fire;
   logic        out_fire;
   logic        timed_out;

   riscv_core_decode_stage #(.XLEN(64)) DUT (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_instr(i_instr), .i_instr_valid(i_instr_valid),
      .o_instr_ready(o_instr_ready), .o_dec(o_dec), .o_dec_valid(o_dec_valid),
      .i_dec_ready(i_dec_ready)
   );

   initial begin
      i_clk = 1'b0;
      forever #5 i_clk = ~i_clk;
   end

   //////////////////////////////////////////////////
   // Encoders and expected controls
   //////////////////////////////////////////////////
   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
      return {f7, rs2, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] enc_b(input logic [12:0] b, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
      return {b[12], b[10:5], rs2, rs1, f3, b[4:1], b[11], OPC_BRANCH};
   endfunction

   function automatic logic [31:0] enc_j(input logic [20:0] j, input logic [4:0] rd);
      return {j[20], j[10:1], j[11], j[19:12], rd, OPC_JAL};
   endfunction

   // Expected control vector per instruction class
   function automatic ctrl_t exp_ctrl(input int kind, input logic [1:0] sz, input logic flag);
      ctrl_t c;
      c = '0;
      case (kind)
         K_OP, K_OP32: begin
            c.regwrite = 1'b1;
            c.alu_op   = 1'b1;
            c.is_word  = (kind == K_OP32);
            c.imm_sel  = flag; // M extension
         end
         K_OPIMM: begin
            c.regwrite  = 1'b1;
            c.alu_src_b = 1'b1;
            c.alu_op    = 1'b1;
         end
         K_LOAD, K_AMO: begin
            c.regwrite   = 1'b1;
            c.alu_src_b  = 1'b1;
            c.result_src = 2'd1;
            c.size       = sz;
            c.load_ext   = flag;
            c.mem_write  = (kind == K_AMO);
            c.imm_src    = (kind == K_AMO) ? IMM_ZERO : IMM_I;
         end
         K_STORE: begin
            c.imm_src   = IMM_S;
            c.alu_src_b = 1'b1;
            c.mem_write = 1'b1;
            c.size      = sz;
         end
         K_BRANCH: begin
            c.imm_src   = IMM_B;
            c.alu_src_b = 1'b1;
            c.branch    = 1'b1;
         end
         K_JAL, K_JALR: begin
            c.regwrite   = 1'b1;
            c.imm_src    = (kind == K_JAL) ? IMM_J : IMM_I;
            c.alu_src_b  = 1'b1;
            c.result_src = 2'd2;
            c.jump       = 1'b1;
            c.bj_reg     = (kind == K_JALR);
         end
         K_LUI, K_AUIPC: begin
            c.regwrite  = 1'b1;
            c.imm_src   = IMM_U;
            c.alu_src_b = 1'b1;
            c.u_ctrl    = (kind == K_LUI);
         end
         K_CSR: begin
            c.regwrite   = 1'b1;
            c.imm_src    = IMM_CSR;
            c.result_src = 2'd3;
         end
         default: c = '0;
      endcase
      return c;
   endfunction

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   task automatic add_case(input string name, input logic [31:0] instr, input ctrl_t c,
      input amo_t a, input csr_t s, input alu_op_e alu, input logic ill, input logic rdf,
      input logic nms, input logic [63:0] imm);
      entry_t e;
      e = '{name, instr, c, a, s, alu, ill, rdf, nms, imm};
      tbl.push_back(e);
   endtask

   //////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////
   task automatic check_ctrl(input ctrl_t got, input ctrl_t exp, inout int n);
      if (got !== exp) begin
         $display("** Error o_dec.ctrl got 0x%0h expected 0x%0h", got, exp);
         n++;
      end
   endtask

   task automatic check_amo(input amo_t got, input amo_t exp, inout int n);
      if (got !== exp) begin
         $display("** Error o_dec.amo got 0x%0h expected 0x%0h", got, exp);
         n++;
      end
   endtask

   task automatic check_csr(input csr_t got, input csr_t exp, inout int n);
      if (got !== exp) begin
         $display("** Error o_dec.csr got 0x%0h expected 0x%0h", got, exp);
         n++;
      end
   endtask

   task automatic check_alu(input alu_op_e got, input alu_op_e exp, inout int n);
      if (got !== exp) begin
         $display("** Error o_dec.alu_ctrl got 0x%0h expected 0x%0h", got, exp);
         n++;
      end
   endtask

   task automatic check_imm(input logic [63:0] got, input logic [63:0] exp, inout int n);
      if (got !== exp) begin
         $display("** Error o_dec.imm got 0x%0h expected 0x%0h", got, exp);
         n++;
      end
   endtask

   task automatic check_reg(input string sig, input logic [4:0] got, input logic [4:0] exp,
      inout int n);
      if (got !== exp) begin
         $display("** Error %s got 0x%0h expected 0x%0h", sig, got, exp);
         n++;
      end
   endtask

   task automatic check_flag(input string sig, input logic got, input logic exp, inout int n);
      if (got !== exp) begin
         $display("** Error %s got 0x%0h expected 0x%0h", sig, got, exp);
         n++;
      end
   endtask

   //////////////////////////////////////////////////
   // Stimulus table
   //////////////////////////////////////////////////
   task automatic build_table();
      add_case("add", enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OPC_OP), exp_ctrl(K_OP, 2'd0, 1'b0),
         '0, '0, ALU_ADD, 1'b0, 1'b0, 1'b0, 64'h2);
      add_case("sub", enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3, OPC_OP), exp_ctrl(K_OP, 2'd0, 1'b0),
         '0, '0, ALU_SUB, 1'b0, 1'b0, 1'b0, 64'h402);
      add_case("srai", enc_i(12'h403, 5'd6, 3'd5, 5'd5, OPC_OP_IMM),
         exp_ctrl(K_OPIMM, 2'd0, 1'b0), '0, '0, ALU_SRA, 1'b0, 1'b0, 1'b0, 64'h403);
      add_case("addw", enc_r(7'h00, 5'd9, 5'd8, 3'd0, 5'd7, OPC_OP_32),
         exp_ctrl(K_OP32, 2'd0, 1'b0), '0, '0, ALU_ADD, 1'b0, 1'b0, 1'b0, 64'h9);
      add_case("addi", enc_i(12'hFFB, 5'd2, 3'd0, 5'd1, OPC_OP_IMM),
         exp_ctrl(K_OPIMM, 2'd0, 1'b0), '0, '0, ALU_ADD, 1'b0, 1'b0, 1'b0, -64'sd5);
      add_case("lw", enc_i(12'hFF8, 5'd2, 3'd2, 5'd4, OPC_LOAD), exp_ctrl(K_LOAD, 2'd2, 1'b0),
         '0, '0, ALU_ADD, 1'b0, 1'b1, 1'b0, -64'sd8);
      add_case("lbu", enc_i(12'h010, 5'd2, 3'd4, 5'd4, OPC_LOAD), exp_ctrl(K_LOAD, 2'd0, 1'b1),
         '0, '0, ALU_ADD, 1'b0, 1'b1, 1'b0, 64'h10);
      add_case("sd", {7'h00, 5'd5, 5'd2, 3'd3, 5'd24, OPC_STORE},
         exp_ctrl(K_STORE, 2'd3, 1'b0), '0, '0, ALU_ADD, 1'b0, 1'b0, 1'b0, 64'd24);
      add_case("beq", enc_b(13'h1FF0, 5'd2, 5'd1, 3'd0), exp_ctrl(K_BRANCH, 2'd0, 1'b0),
         '0, '0, ALU_ADD, 1'b0, 1'b0, 1'b1, -64'sd16);
      add_case("jal", enc_j(21'h1FF800, 5'd1), exp_ctrl(K_JAL, 2'd0, 1'b0),
         '0, '0, ALU_ADD, 1'b0, 1'b0, 1'b1, -64'sd2048);
      add_case("jalr", enc_i(12'h00C, 5'd1, 3'd0, 5'd0, OPC_JALR), exp_ctrl(K_JALR, 2'd0, 1'b0),
         '0, '0, ALU_ADD, 1'b0, 1'b0, 1'b1, 64'hC);
      add_case("lui", {20'h80000, 5'd5, OPC_LUI}, exp_ctrl(K_LUI, 2'd0, 1'b0),
         '0, '0, ALU_ADD, 1'b0, 1'b1, 1'b1, 64'hFFFF_FFFF_8000_0000);
      add_case("auipc", {20'h12345, 5'd6, OPC_AUIPC}, exp_ctrl(K_AUIPC, 2'd0, 1'b0),
         '0, '0, ALU_ADD, 1'b0, 1'b0, 1'b1, 64'h1234_5000);
      add_case("mul", enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd3, OPC_OP), exp_ctrl(K_OP, 2'd0, 1'b1),
         '0, '0, ALU_MUL, 1'b0, 1'b0, 1'b0, 64'h22);
      add_case("divu", enc_r(7'h01, 5'd2, 5'd1, 3'd5, 5'd3, OPC_OP), exp_ctrl(K_OP, 2'd0, 1'b1),
         '0, '0, ALU_DIV, 1'b0, 1'b0, 1'b0, 64'h22);
      add_case("remw", enc_r(7'h01, 5'd2, 5'd1, 3'd6, 5'd3, OPC_OP_32),
         exp_ctrl(K_OP32, 2'd0, 1'b1), '0, '0, ALU_REM, 1'b0, 1'b0, 1'b0, 64'h22);
      add_case("lr.w", enc_r(7'h08, 5'd0, 5'd1, 3'd2, 5'd5, OPC_AMO),
         exp_ctrl(K_AMO, 2'd2, 1'b0), amo_t'(7'b0000010), '0, ALU_ADD, 1'b0, 1'b1, 1'b0, 64'h0);
      add_case("sc.d", enc_r(7'h0C, 5'd2, 5'd1, 3'd3, 5'd5, OPC_AMO),
         exp_ctrl(K_AMO, 2'd3, 1'b0), amo_t'(7'b0000001), '0, ALU_ADD, 1'b0, 1'b0, 1'b0, 64'h0);
      add_case("amoswap.w", enc_r(7'h04, 5'd2, 5'd1, 3'd2, 5'd5, OPC_AMO),
         exp_ctrl(K_AMO, 2'd2, 1'b0), amo_t'(7'b1000000), '0, ALU_ADD, 1'b0, 1'b1, 1'b0, 64'h0);
      add_case("amoadd.d", enc_r(7'h00, 5'd2, 5'd1, 3'd3, 5'd5, OPC_AMO),
         exp_ctrl(K_AMO, 2'd3, 1'b0), amo_t'(7'b1000100), '0, ALU_ADD, 1'b0, 1'b1, 1'b0, 64'h0);
      add_case("amomaxu.w", enc_r(7'h70, 5'd2, 5'd1, 3'd2, 5'd5, OPC_AMO),
         exp_ctrl(K_AMO, 2'd2, 1'b1), amo_t'(7'b1011100), '0, ALU_ADD, 1'b0, 1'b1, 1'b0, 64'h0);
      add_case("csrrw", enc_i(12'h300, 5'd1, 3'd1, 5'd5, OPC_SYSTEM), exp_ctrl(K_CSR, 2'd0, 1'b0),
         '0, csr_t'(3'b001), ALU_ADD, 1'b0, 1'b0, 1'b0, 64'h1);
      add_case("csrrs", enc_i(12'h300, 5'd2, 3'd2, 5'd5, OPC_SYSTEM), exp_ctrl(K_CSR, 2'd0, 1'b0),
         '0, csr_t'(3'b010), ALU_ADD, 1'b0, 1'b0, 1'b0, 64'h2);
      add_case("csrrci", enc_i(12'h300, 5'd7, 3'd7, 5'd5, OPC_SYSTEM),
         exp_ctrl(K_CSR, 2'd0, 1'b0), '0, csr_t'(3'b111), ALU_ADD, 1'b0, 1'b0, 1'b0, 64'h7);
      add_case("bad 7f", 32'h0000_007F, exp_ctrl(K_BAD, 2'd0, 1'b0), '0, '0, ALU_ADD,
         1'b1, 1'b0, 1'b0, 64'h0);
      add_case("bad 00", 32'h0000_0000, exp_ctrl(K_BAD, 2'd0, 1'b0), '0, '0, ALU_ADD,
         1'b1, 1'b0, 1'b0, 64'h0);
      add_case("bad 57", 32'h0000_0057, exp_ctrl(K_BAD, 2'd0, 1'b0), '0, '0, ALU_ADD,
         1'b1, 1'b0, 1'b0, 64'h0);
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////
   initial begin
      i_rst_n       = 1'b0;
      i_instr       = '0;
      i_instr_valid = 1'b0;
      i_dec_ready   = 1'b0;
      rng           = 32'd42;
      sent          = 0;
      recv          = 0;
      pass_cnt      = 0;
      fail_cnt      = 0;
      proto_errs    = 0;
      idle          = 0;
      in_fire       = 1'b0;
      out_fire      = 1'b0;
      timed_out     = 1'b0;
      build_table();
      repeat (4) @(negedge i_clk);
      i_rst_n = 1'b1;

      while (recv < tbl.size() && !timed_out) begin
         @(negedge i_clk);
         if (in_fire) begin
            // Accepted at the last rising edge, so it must be on the output now
            if (o_dec_valid !== 1'b1) begin
               $display("Entry %0d was accepted but is not on the output one cycle later",
                        sent);
               proto_errs++;
            end
            sent++;
         end
         rng           = xorshift32(rng);
         i_dec_ready   = (rng[1:0] != 2'b00); // Stall about one cycle in four
         i_instr_valid = (sent < tbl.size());
         i_instr       = (sent < tbl.size()) ? tbl[sent].instr : 32'h0;
         #1;
         in_fire  = i_instr_valid && o_instr_ready;
         out_fire = o_dec_valid && i_dec_ready;
         if (out_fire) begin
            errs = 0;
            check_ctrl(o_dec.ctrl, tbl[recv].ctrl, errs);
            check_amo(o_dec.amo, tbl[recv].amo, errs);
            check_csr(o_dec.csr, tbl[recv].csr, errs);
            check_alu(o_dec.alu_ctrl, tbl[recv].alu, errs);
            check_imm(o_dec.imm, tbl[recv].imm, errs);
            check_reg("o_dec.rd", o_dec.rd, tbl[recv].instr[11:7], errs);
            check_reg("o_dec.rs1", o_dec.rs1, tbl[recv].instr[19:15], errs);
            check_reg("o_dec.rs2", o_dec.rs2, tbl[recv].instr[24:20], errs);
            check_flag("o_dec.illegal", o_dec.illegal, tbl[recv].ill, errs);
            check_flag("o_dec.read", o_dec.read, tbl[recv].rd_flag, errs);
            check_flag("o_dec.new_mux_sel", o_dec.new_mux_sel, tbl[recv].new_mux, errs);
            if (errs == 0) begin
               pass_cnt++;
               $display("[ok]  %0d %s", recv, tbl[recv].name);
            end
            else begin
               fail_cnt++;
               $display("[bad] %0d %s with %0d mismatches", recv, tbl[recv].name, errs);
            end
            recv++;
            idle = 0;
         end
         else begin
            idle++;
            if (idle > 40) begin
               $display("Timeout: no decoded output for 40 cycles at entry %0d", recv);
               timed_out = 1'b1;
            end
         end
      end

      // Every entry has left, so the register must now be empty
      if (!timed_out) begin
         @(negedge i_clk);
         if (o_dec_valid !== 1'b0) begin
            $display("Extra decoded output after the last table entry");
            proto_errs++;
         end
      end

      $display("Summary: %0d passed, %0d failed of %0d, %0d handshake errors",
               pass_cnt, fail_cnt, tbl.size(), proto_errs);
      if (fail_cnt == 0 && proto_errs == 0 && !timed_out) begin
         $display("Test completed successfully");
      end
      else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== compile.f ====
common/riscv_core_pkg.sv
source/riscv_core_main_decoder.sv
source/riscv_core_alu_decoder.sv
source/riscv_core_imm_extend.sv
source/riscv_core_decode_stage.sv
tests/riscv_core_decode_checker.sv
tests/riscv_core_decode_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= riscv_core_decode_tb
FLIST     ?= compile.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and scan the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
